//--- common/sm_macros.svh
`ifndef SM_MACROS_SVH
`define SM_MACROS_SVH

// Core sizes.
`define SM_DATA_W     16 // Width of every register and of the datapath.
`define SM_NREGS      8  // General registers R0 to R7.
`define SM_REG_IDX_W  3  // Bits needed to address one general register.
`define SM_IMM_W      8  // Immediate field of MOV Rn,#imm8.

// Lowest bit of each field in the 16-bit instruction word.
`define SM_OPC_LSB    13 // opcode in [15:13].
`define SM_OP_LSB     11 // op in [12:11].
`define SM_RN_LSB     8  // Rn in [10:8].
`define SM_RD_LSB     5  // Rd in [7:5].
`define SM_SH_LSB     3  // shift in [4:3].

`endif

//--- common/sm_pkg.sv
package sm_pkg;

    // --------------------
    // Instruction fields
    // --------------------

    // Only two opcodes are decoded. Everything else leaves the core waiting.
    typedef enum logic [2:0] {
        OPC_ALU = 3'b101, // ADD, CMP, AND and MVN.
        OPC_MOV = 3'b110  // MOV immediate and MOV register.
    } opcode_e;

    // The op field also picks the MOV variant, so 00 and 10 double as the two MOV forms.
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01, // Used by CMP.
        ALU_AND = 2'b10,
        ALU_NOT = 2'b11  // Used by MVN.
    } alu_op_e;

    // Shift applied to the B operand on its way into the ALU.
    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL1 = 2'b01, // Left by one, zero in.
        SH_LSR1 = 2'b10, // Right by one, zero in.
        SH_ASR1 = 2'b11  // Right by one, sign bit copied in.
    } shift_op_e;

    // --------------------
    // Control encodings
    // --------------------

    // Which register field of the instruction addresses the register file.
    typedef enum logic [1:0] {
        RSEL_RM = 2'b00,
        RSEL_RD = 2'b01,
        RSEL_RN = 2'b10
    } reg_sel_e;

    // Source of the register file write data.
    typedef enum logic [1:0] {
        WB_C   = 2'b00, // Result register C.
        WB_IMM = 2'b10  // Sign-extended immediate.
    } wb_sel_e;

    // Controller states. Each instruction walks its own fixed chain.
    typedef enum logic [4:0] {
        S_WAIT,
        S_MOVI,
        S_MOV1, S_MOV2, S_MOV3,
        S_MVN1, S_MVN2, S_MVN3,
        S_ADD1, S_ADD2, S_ADD3, S_ADD4,
        S_CMP1, S_CMP2, S_CMP3, S_CMP4,
        S_AND1, S_AND2, S_AND3, S_AND4
    } ctrl_state_e;

endpackage

//--- datapath/sm_regfile.sv
`timescale 1ns/100ps
`include "sm_macros.svh"

module sm_regfile (
    input  logic                     clk,
    input  logic                     w_en,
    input  logic [`SM_REG_IDX_W-1:0] idx,   // Shared by the read and the write port.
    input  logic [`SM_DATA_W-1:0]    wdata,
    output logic [`SM_DATA_W-1:0]    rdata
);

    // Eight general registers. Contents are unknown until first written.
    logic [`SM_DATA_W-1:0] regs [`SM_NREGS];

    // Write at the clock edge.
    always_ff @(posedge clk) begin
        if (w_en) begin
            regs[idx] <= wdata;
        end
    end

    // Read is combinational. A write shows up on rdata after the edge.
    assign rdata = regs[idx];

endmodule

//--- datapath/sm_datapath.sv
`timescale 1ns/100ps
`include "sm_macros.svh"

module sm_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`SM_REG_IDX_W-1:0] reg_idx,
    input  logic                     w_en,
    input  sm_pkg::wb_sel_e          wb_sel,
    input  logic [`SM_DATA_W-1:0]    sximm8,
    input  sm_pkg::shift_op_e        shift_op,
    input  sm_pkg::alu_op_e          alu_op,
    input  logic                     en_a,
    input  logic                     en_b,
    input  logic                     en_c,
    input  logic                     en_status,
    input  logic                     sel_a,
    output logic [`SM_DATA_W-1:0]    out,
    output logic                     z,
    output logic                     n,
    output logic                     v
);

    localparam int MSB = `SM_DATA_W - 1;

    logic [MSB:0] rdata;   // Register file read port.
    logic [MSB:0] wdata;   // Register file write port.
    logic [MSB:0] a_q;     // Operand A, holds Rn.
    logic [MSB:0] b_q;     // Operand B, holds Rm before the shift.
    logic [MSB:0] c_q;     // Result register.
    logic [MSB:0] a_in;
    logic [MSB:0] b_sh;
    logic [MSB:0] diff;
    logic [MSB:0] alu_res;
    logic         sub_ovf;
    logic         z_q;
    logic         n_q;
    logic         v_q;

    sm_regfile u_regfile (
        .clk   (clk),
        .w_en  (w_en),
        .idx   (reg_idx),
        .wdata (wdata),
        .rdata (rdata)
    );

    // Operand registers hold whatever was last read. They carry no reset.
    always_ff @(posedge clk) begin
        if (en_a) a_q <= rdata;
        if (en_b) b_q <= rdata;
    end

    // --------------------
    // Shifter and ALU
    // --------------------

    always_comb begin
        case (shift_op)
            sm_pkg::SH_LSL1: b_sh = {b_q[MSB-1:0], 1'b0};
            sm_pkg::SH_LSR1: b_sh = {1'b0, b_q[MSB:1]};
            sm_pkg::SH_ASR1: b_sh = {b_q[MSB], b_q[MSB:1]};
            default:         b_sh = b_q;
        endcase
    end

    assign a_in = sel_a ? '0 : a_q; // Moves add shifted B to zero.
    assign diff = a_in - b_sh;

    // Signed overflow of A minus B. Operands differ in sign and the result
    // takes the sign of B.
    assign sub_ovf = (a_in[MSB] ^ b_sh[MSB]) & (diff[MSB] ^ a_in[MSB]);

    always_comb begin
        case (alu_op)
            sm_pkg::ALU_ADD: alu_res = a_in + b_sh;
            sm_pkg::ALU_SUB: alu_res = diff;
            sm_pkg::ALU_AND: alu_res = a_in & b_sh;
            default:         alu_res = ~b_sh; // MVN ignores A.
        endcase
    end

    // --------------------
    // Result and flags
    // --------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_q <= '0;
            z_q <= 1'b0;
            n_q <= 1'b0;
            v_q <= 1'b0;
        end else begin
            if (en_c) c_q <= alu_res;
            // Only CMP raises en_status, so the ALU is subtracting here.
            if (en_status) begin
                z_q <= (alu_res == '0);
                n_q <= alu_res[MSB];
                v_q <= sub_ovf;
            end
        end
    end

    // Writeback is either the result or the immediate.
    assign wdata = (wb_sel == sm_pkg::WB_IMM) ? sximm8 : c_q;

    assign out = c_q;
    assign z   = z_q;
    assign n   = n_q;
    assign v   = v_q;

endmodule

//--- controller/sm_instr_decoder.sv
`timescale 1ns/100ps
`include "sm_macros.svh"

module sm_instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [15:0]              instr,
    input  logic                     load,
    input  sm_pkg::reg_sel_e         reg_sel,
    output sm_pkg::opcode_e          opcode,
    output sm_pkg::alu_op_e          alu_op,
    output sm_pkg::shift_op_e        shift_op,
    output logic [`SM_REG_IDX_W-1:0] reg_idx,
    output logic [`SM_DATA_W-1:0]    sximm8
);

    logic [15:0] ir; // Instruction register.
    logic [`SM_REG_IDX_W-1:0] rn;
    logic [`SM_REG_IDX_W-1:0] rd;
    logic [`SM_REG_IDX_W-1:0] rm;

    // Reset leaves opcode 000, which the controller never accepts.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (load) begin
            ir <= instr; // The host must not load while the core is busy.
        end
    end

    // --------------------
    // Field split
    // --------------------

    assign opcode   = sm_pkg::opcode_e'(ir[`SM_OPC_LSB +: 3]);
    assign alu_op   = sm_pkg::alu_op_e'(ir[`SM_OP_LSB +: 2]);
    assign shift_op = sm_pkg::shift_op_e'(ir[`SM_SH_LSB +: 2]);
    assign rn       = ir[`SM_RN_LSB +: `SM_REG_IDX_W];
    assign rd       = ir[`SM_RD_LSB +: `SM_REG_IDX_W];
    assign rm       = ir[`SM_REG_IDX_W-1:0]; // Rm sits in the lowest bits.

    // The immediate overlaps Rd, shift and Rm. Only MOV imm uses it.
    assign sximm8 = {{(`SM_DATA_W-`SM_IMM_W){ir[`SM_IMM_W-1]}}, ir[`SM_IMM_W-1:0]};

    // One read/write index for the register file, chosen by the controller state.
    always_comb begin
        case (reg_sel)
            sm_pkg::RSEL_RN: reg_idx = rn;
            sm_pkg::RSEL_RD: reg_idx = rd;
            default:         reg_idx = rm;
        endcase
    end

endmodule

//--- controller/sm_controller.sv
`timescale 1ns/100ps

module sm_controller (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  sm_pkg::opcode_e  opcode,
    input  sm_pkg::alu_op_e  alu_op,
    output logic             waiting,
    output sm_pkg::reg_sel_e reg_sel,
    output sm_pkg::wb_sel_e  wb_sel,
    output logic             w_en,
    output logic             en_a,
    output logic             en_b,
    output logic             en_c,
    output logic             en_status,
    output logic             sel_a
);

    sm_pkg::ctrl_state_e state;
    sm_pkg::ctrl_state_e state_nxt;

    // --------------------
    // Next state
    // --------------------

    always_comb begin
        state_nxt = sm_pkg::S_WAIT; // Every chain ends back in S_WAIT.
        case (state)
            sm_pkg::S_WAIT: begin
                // Branch on opcode and op. Unknown encodings simply stay here.
                if (start && opcode == sm_pkg::OPC_ALU) begin
                    case (alu_op)
                        sm_pkg::ALU_ADD: state_nxt = sm_pkg::S_ADD1;
                        sm_pkg::ALU_SUB: state_nxt = sm_pkg::S_CMP1;
                        sm_pkg::ALU_AND: state_nxt = sm_pkg::S_AND1;
                        default:         state_nxt = sm_pkg::S_MVN1;
                    endcase
                end else if (start && opcode == sm_pkg::OPC_MOV
                             && alu_op == sm_pkg::ALU_AND) begin
                    state_nxt = sm_pkg::S_MOVI; // op 10 is the immediate form.
                end else if (start && opcode == sm_pkg::OPC_MOV
                             && alu_op == sm_pkg::ALU_ADD) begin
                    state_nxt = sm_pkg::S_MOV1; // op 00 is the register form.
                end
            end
            sm_pkg::S_MOV1: state_nxt = sm_pkg::S_MOV2;
            sm_pkg::S_MOV2: state_nxt = sm_pkg::S_MOV3;
            sm_pkg::S_MVN1: state_nxt = sm_pkg::S_MVN2;
            sm_pkg::S_MVN2: state_nxt = sm_pkg::S_MVN3;
            sm_pkg::S_ADD1: state_nxt = sm_pkg::S_ADD2;
            sm_pkg::S_ADD2: state_nxt = sm_pkg::S_ADD3;
            sm_pkg::S_ADD3: state_nxt = sm_pkg::S_ADD4;
            sm_pkg::S_CMP1: state_nxt = sm_pkg::S_CMP2;
            sm_pkg::S_CMP2: state_nxt = sm_pkg::S_CMP3;
            sm_pkg::S_CMP3: state_nxt = sm_pkg::S_CMP4;
            sm_pkg::S_AND1: state_nxt = sm_pkg::S_AND2;
            sm_pkg::S_AND2: state_nxt = sm_pkg::S_AND3;
            sm_pkg::S_AND3: state_nxt = sm_pkg::S_AND4;
            default:        state_nxt = sm_pkg::S_WAIT; // MOVI, MOV3, MVN3, ADD4, CMP4, AND4.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sm_pkg::S_WAIT;
        end else begin
            state <= state_nxt;
        end
    end

    // --------------------
    // Moore outputs
    // --------------------

    assign waiting = (state == sm_pkg::S_WAIT); // Low for the whole execution.

    always_comb begin
        // Idle values. Rm is the default index since most states read it or do not care.
        reg_sel   = sm_pkg::RSEL_RM;
        wb_sel    = sm_pkg::WB_C;
        w_en      = 1'b0;
        en_a      = 1'b0;
        en_b      = 1'b0;
        en_c      = 1'b0;
        en_status = 1'b0;
        sel_a     = 1'b0;
        case (state)
            // First step of the three-operand forms loads A from Rn.
            sm_pkg::S_ADD1, sm_pkg::S_CMP1, sm_pkg::S_AND1: begin
                reg_sel = sm_pkg::RSEL_RN;
                en_a    = 1'b1;
            end
            // B always comes from Rm, which is the default index.
            sm_pkg::S_ADD2, sm_pkg::S_CMP2, sm_pkg::S_AND2,
            sm_pkg::S_MVN1, sm_pkg::S_MOV1: begin
                en_b = 1'b1;
            end
            sm_pkg::S_ADD3, sm_pkg::S_AND3: begin
                en_c = 1'b1; // Capture Rn op shifted Rm.
            end
            // The moves force A to zero so the ALU passes shifted B through.
            sm_pkg::S_MVN2, sm_pkg::S_MOV2: begin
                en_c  = 1'b1;
                sel_a = 1'b1;
            end
            sm_pkg::S_ADD4, sm_pkg::S_AND4, sm_pkg::S_MVN3, sm_pkg::S_MOV3: begin
                reg_sel = sm_pkg::RSEL_RD; // Write C back to Rd.
                w_en    = 1'b1;
            end
            sm_pkg::S_MOVI: begin
                reg_sel = sm_pkg::RSEL_RN; // The immediate form targets Rn.
                wb_sel  = sm_pkg::WB_IMM;
                w_en    = 1'b1;
            end
            sm_pkg::S_CMP4: en_status = 1'b1; // CMP3 is a settle cycle with no enables.
            default: ;
        endcase
    end

endmodule

//--- design/sm_cpu.sv
`timescale 1ns/100ps
`include "sm_macros.svh"

module sm_cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [15:0]           instr,   // Instruction word from the host.
    input  logic                  load,    // Captures instr into the instruction register.
    input  logic                  start,   // Begins execution of the stored instruction.
    output logic [`SM_DATA_W-1:0] out,     // Mirror of result register C.
    output logic                  z,
    output logic                  n,
    output logic                  v,
    output logic                  waiting  // High while the core is idle.
);

    // Decoder to controller and datapath.
    sm_pkg::opcode_e   opcode;
    sm_pkg::alu_op_e   alu_op;
    sm_pkg::shift_op_e shift_op;
    logic [`SM_REG_IDX_W-1:0] reg_idx;
    logic [`SM_DATA_W-1:0]    sximm8;

    // Controller to decoder and datapath.
    sm_pkg::reg_sel_e reg_sel;
    sm_pkg::wb_sel_e  wb_sel;
    logic w_en;
    logic en_a;
    logic en_b;
    logic en_c;
    logic en_status;
    logic sel_a;

    sm_instr_decoder u_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr    (instr),
        .load     (load),
        .reg_sel  (reg_sel),
        .opcode   (opcode),
        .alu_op   (alu_op),
        .shift_op (shift_op),
        .reg_idx  (reg_idx),
        .sximm8   (sximm8)
    );

    sm_controller u_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .opcode    (opcode),
        .alu_op    (alu_op),
        .waiting   (waiting),
        .reg_sel   (reg_sel),
        .wb_sel    (wb_sel),
        .w_en      (w_en),
        .en_a      (en_a),
        .en_b      (en_b),
        .en_c      (en_c),
        .en_status (en_status),
        .sel_a     (sel_a)
    );

    sm_datapath u_datapath (
        .clk (clk), .rst_n (rst_n),
        .reg_idx (reg_idx), .w_en (w_en), .wb_sel (wb_sel), .sximm8 (sximm8),
        .shift_op (shift_op), .alu_op (alu_op),
        .en_a (en_a), .en_b (en_b), .en_c (en_c), .en_status (en_status), .sel_a (sel_a),
        .out (out), .z (z), .n (n), .v (v)
    );

endmodule

//--- test/sm_cpu_tb.sv
`timescale 1ns/100ps

module sm_cpu_tb;

    // About 70 instructions at under 10 cycles each, so 2000 leaves ample margin.
    localparam int MAX_CYCLES = 2000;
    localparam int OP_ADD = 0;
    localparam int OP_CMP = 1;
    localparam int OP_AND = 2;
    localparam int OP_MVN = 3;
    localparam int SH_NONE = 0;
    localparam int SH_LSR = 2;

    logic clk;
    logic rst_n;
    logic [15:0] instr;
    logic load;
    logic start;
    logic [15:0] out;
    logic z, n, v;
    logic waiting;

    logic [15:0] model_regs [8]; // Reference copy of R0 to R7.
    logic [15:0] model_c;        // Reference copy of result register C.
    logic model_z, model_n, model_v;

    logic        idle_before;    // Values seen just before the latest rising edge.
    logic [15:0] out_before;
    logic [2:0]  flags_before;

    int seed = 1353;
    int errors = 0;
    int checks = 0;
    int test_num = 0;
    int test_err0 = 0;
    int cycle_count = 0;
    string test_name;

    sm_cpu dut (
        .clk (clk), .rst_n (rst_n), .instr (instr), .load (load), .start (start),
        .out (out), .z (z), .n (n), .v (v), .waiting (waiting)
    );

    // --------------------
    // Clock and watchdog
    // --------------------

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles.", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    // --------------------
    // Concurrent checks
    // --------------------

    always @(posedge clk) begin
        idle_before  <= waiting; // Old values, since the DUT updates at this same edge.
        out_before   <= out;
        flags_before <= {z, n, v};
    end

    // C only moves while an instruction runs.
    idle_keeps_out: assert property (@(negedge clk) disable iff (!rst_n)
        idle_before |-> (out == out_before))
        else begin
            errors++;
            $display("CHECK FAILED t=%0t out expected %h actual %h", $time, out_before, out);
        end

    // The same holds for the status flags.
    idle_keeps_flags: assert property (@(negedge clk) disable iff (!rst_n)
        idle_before |-> ({z, n, v} == flags_before))
        else begin
            errors++;
            $display("CHECK FAILED t=%0t {z,n,v} expected %b actual %b", $time,
                     flags_before, {z, n, v});
        end

    // --------------------
    // Checkers
    // --------------------

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, got);
        end
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        $display("test %0d %s: %0d errors", test_num, test_name, errors - test_err0);
    endtask

    // --------------------
    // Encoding and model
    // --------------------

    function automatic logic [15:0] enc_movi(input int rn, input logic [7:0] imm);
        return {3'b110, 2'b10, rn[2:0], imm};
    endfunction

    function automatic logic [15:0] enc_movr(input int rd, input int rm, input int sh);
        return {3'b110, 2'b00, 3'b000, rd[2:0], sh[1:0], rm[2:0]};
    endfunction

    function automatic logic [15:0] enc_alu(input int op, input int rd, input int rn,
                                            input int rm, input int sh);
        return {3'b101, op[1:0], rn[2:0], rd[2:0], sh[1:0], rm[2:0]};
    endfunction

    function automatic int rand_int(input int mask);
        int r;
        r = $random(seed);
        return r & mask;
    endfunction

    // Busy cycles of each instruction. Unknown encodings never leave the wait state.
    function automatic int expected_busy(input logic [15:0] w);
        if (w[15:13] == 3'b110 && w[12:11] == 2'b10) return 1;
        if (w[15:13] == 3'b110 && w[12:11] == 2'b00) return 3;
        if (w[15:13] == 3'b101) return (w[12:11] == 2'b11) ? 3 : 4;
        return 0;
    endfunction

    function automatic logic [15:0] shift_ref(input logic [15:0] x, input logic [1:0] sh);
        case (sh)
            2'b01:   return {x[14:0], 1'b0};
            2'b10:   return {1'b0, x[15:1]};
            2'b11:   return {x[15], x[15:1]}; // Arithmetic, sign kept.
            default: return x;
        endcase
    endfunction

    task automatic update_model(input logic [15:0] w);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] d;
        int sa;
        int sb;
        int sd;
        a = model_regs[w[10:8]];
        b = shift_ref(model_regs[w[2:0]], w[4:3]);
        d = a - b;
        if (w[15:13] == 3'b110 && w[12:11] == 2'b10) begin
            model_regs[w[10:8]] = {{8{w[7]}}, w[7:0]}; // C is left alone.
        end else if (w[15:13] == 3'b110 && w[12:11] == 2'b00) begin
            model_c = b;
            model_regs[w[7:5]] = b;
        end else if (w[15:13] == 3'b101) begin
            case (w[12:11])
                2'b00: model_c = a + b;
                2'b10: model_c = a & b;
                2'b11: model_c = ~b;
                default: begin // CMP touches only the flags.
                    sa = {{16{a[15]}}, a};
                    sb = {{16{b[15]}}, b};
                    sd = sa - sb; // Exact signed difference in 32 bits.
                    model_z = (d == 16'h0000);
                    model_n = d[15];
                    model_v = (sd > 32767) || (sd < -32768); // Outside the 16-bit range.
                end
            endcase
            if (w[12:11] != 2'b01) model_regs[w[7:5]] = model_c;
        end
    endtask

    // Load, start, count busy cycles, then compare against the model.
    task automatic run_instr(input logic [15:0] word, input bit poke_start);
        int busy;
        int exp_busy;
        busy = 0;
        exp_busy = expected_busy(word);
        @(posedge clk); #1;
        instr = word;
        load = 1'b1;
        @(posedge clk); #1;
        load = 1'b0;
        start = 1'b1;
        @(posedge clk); #1;
        start = 1'b0;
        while (waiting !== 1'b1) begin
            busy++;
            if (poke_start && busy == 1) start = 1'b1; // Must be ignored while busy.
            @(posedge clk); #1;
            start = 1'b0;
        end
        update_model(word);
        check_count("waiting low cycles", exp_busy, busy);
        check_word("out", model_c, out);
        check_bit("z", model_z, z);
        check_bit("n", model_n, n);
        check_bit("v", model_v, v);
        if (poke_start || exp_busy == 0) begin
            repeat (2) begin
                @(posedge clk); #1;
                check_bit("waiting", 1'b1, waiting); // No second run starts.
            end
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        rst_n = 1'b0;
        instr = 16'h0000;
        load  = 1'b0;
        start = 1'b0;
        model_c = 16'h0000;
        model_z = 1'b0;
        model_n = 1'b0;
        model_v = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        begin_test("reset state and invalid opcodes");
        check_bit("waiting", 1'b1, waiting);
        check_word("out", 16'h0000, out);
        check_bit("z", 1'b0, z);
        check_bit("n", 1'b0, n);
        check_bit("v", 1'b0, v);
        run_instr(16'h0000, 1'b0);
        run_instr(16'hC812, 1'b0); // MOV with op 01 is not defined.
        end_test();

        begin_test("busy cycles per instruction");
        run_instr(enc_movi(0, 8'h05), 1'b0);
        run_instr(enc_movr(1, 0, SH_NONE), 1'b0);
        run_instr(enc_alu(OP_MVN, 2, 0, 1, SH_NONE), 1'b0);
        run_instr(enc_alu(OP_ADD, 3, 0, 1, SH_NONE), 1'b0);
        run_instr(enc_alu(OP_AND, 4, 0, 2, SH_NONE), 1'b0);
        run_instr(enc_alu(OP_CMP, 0, 0, 1, SH_NONE), 1'b0);
        end_test();

        begin_test("MOV immediate sign extension");
        run_instr(enc_movi(5, 8'h7F), 1'b0);
        run_instr(enc_movr(6, 5, SH_NONE), 1'b0);
        run_instr(enc_movi(5, 8'h80), 1'b0);
        run_instr(enc_movr(6, 5, SH_NONE), 1'b0);
        run_instr(enc_movi(7, 8'hFE), 1'b0);
        run_instr(enc_movr(0, 7, SH_NONE), 1'b0);
        end_test();

        begin_test("ADD, AND and MVN with shifts");
        for (int k = 0; k < 8; k++) begin
            run_instr(enc_movi(k, 8'(rand_int(255))), 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            case (rand_int(3))
                0: run_instr(enc_alu(OP_AND, rand_int(7), rand_int(7), rand_int(7), i % 4), 1'b0);
                1: run_instr(enc_alu(OP_MVN, rand_int(7), rand_int(7), rand_int(7), i % 4), 1'b0);
                default: begin
                    run_instr(enc_alu(OP_ADD, rand_int(7), rand_int(7), rand_int(7), i % 4), 1'b0);
                end
            endcase
        end
        end_test();

        begin_test("CMP flags");
        run_instr(enc_movi(0, 8'hFF), 1'b0);
        run_instr(enc_movr(1, 0, SH_LSR), 1'b0);             // R1 = 0x7FFF.
        run_instr(enc_alu(OP_MVN, 2, 0, 1, SH_NONE), 1'b0);  // R2 = 0x8000.
        run_instr(enc_movi(3, 8'h05), 1'b0);
        run_instr(enc_movi(4, 8'h05), 1'b0);
        run_instr(enc_alu(OP_CMP, 0, 2, 1, SH_NONE), 1'b0);  // Overflow to positive.
        run_instr(enc_alu(OP_CMP, 0, 1, 2, SH_NONE), 1'b0);  // Overflow to negative.
        run_instr(enc_alu(OP_CMP, 0, 3, 4, SH_NONE), 1'b0);  // Equal operands set Z.
        run_instr(enc_alu(OP_CMP, 0, 3, 1, SH_NONE), 1'b0);
        for (int i = 0; i < 6; i++) begin
            run_instr(enc_alu(OP_CMP, 0, rand_int(7), rand_int(7), i % 4), 1'b0);
        end
        end_test();

        begin_test("start while busy");
        run_instr(enc_alu(OP_ADD, 5, 1, 2, SH_NONE), 1'b1);
        run_instr(enc_movi(6, 8'h33), 1'b1);
        run_instr(enc_alu(OP_MVN, 7, 0, 3, 1), 1'b1);
        run_instr(enc_alu(OP_CMP, 0, 4, 3, SH_NONE), 1'b1);
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sm_cpu.f
+incdir+common
common/sm_pkg.sv
datapath/sm_regfile.sv
datapath/sm_datapath.sv
controller/sm_instr_decoder.sv
controller/sm_controller.sv
design/sm_cpu.sv
test/sm_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the run from its log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module sm_cpu_tb -f sm_cpu.f -o sm_cpu_sim > build.log 2>&1 \
    && ./obj_dir/sm_cpu_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log

# The fail message decides the verdict; a missing pass message also counts as failure.
grep -q "Testbench failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Result: no verdict in sim.log"; exit 1; }
echo "Result: PASS"
exit 0
